/* vlog.f */
logic/tia_pkg.sv
logic/tia_write_registers.sv
logic/tia_horizontal_timing.sv
logic/tia_playfield.sv
logic/tia_color_lum.sv
logic/tia_video.sv
verif/tia_clock_gen.sv
verif/tia_video_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tia_video_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tia_video_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module tia_video_tb;

  localparam int num_lines = 40;
  localparam int run_cycles = num_lines * 228;
  localparam int timeout_ns = (run_cycles + 10 + 500) * 40;

  logic            clk;
  logic            rst;
  logic [5:0]      a;
  logic [7:0]      d;
  logic            we;
  tia_pkg::lum_t   l;
  tia_pkg::color_t c;
  logic            blk_bar;
  logic            syn;
  logic            rdy;

  // reference model state
  tia_pkg::hpos_t       m_hpos;
  logic                 m_vsync, m_vblank, m_reflect, m_score, m_rdy;
  logic [7:0]           m_pf0, m_pf1, m_pf2;
  tia_pkg::write_word_u m_col [4];  // p0, p1, pf, bk
  tia_pkg::lum_t        exp_l;
  tia_pkg::color_t      exp_c;
  logic                 exp_blk, exp_syn;
  logic                 armed = 1'b0;

  logic [31:0] lfsr_state = 32'h0741d395;
  int          pixel_errors = 0;
  int          bit_errors = 0;

  tia_clock_gen clock_gen (.clk(clk), .rst(rst));

  tia_video DUT (
    .clk(clk), .rst(rst), .a(a), .d(d), .we(we),
    .l(l), .c(c), .blk_bar(blk_bar), .syn(syn), .rdy(rdy)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [5:0] addr_for(input logic [3:0] idx);
    case (idx)
      4'd0: return tia_pkg::addr_vsync;
      4'd1: return tia_pkg::addr_vblank;
      4'd2: return tia_pkg::addr_colup0;
      4'd3: return tia_pkg::addr_colup1;
      4'd4: return tia_pkg::addr_colupf;
      4'd5: return tia_pkg::addr_colubk;
      4'd6: return tia_pkg::addr_ctrlpf;
      4'd7: return tia_pkg::addr_pf0;
      4'd8: return tia_pkg::addr_pf1;
      default: return tia_pkg::addr_pf2;
    endcase
  endfunction

  // which colour register a visible pixel takes
  function automatic logic [1:0] pixel_source(input tia_pkg::hpos_t pos);
    int   slot;
    logic lit;
    slot = (int'(pos) - int'(tia_pkg::hblank_end)) / 4;
    if (pos >= tia_pkg::half_line) begin
      slot = m_reflect ? 39 - slot : slot - 20;
    end
    if (slot < 4) lit = m_pf0[3'(slot + 4)];
    else if (slot < 12) lit = m_pf1[3'(11 - slot)];  // pf1 msb first
    else lit = m_pf2[3'(slot - 12)];
    if (!lit) return 2'd3;
    else if (!m_score) return 2'd2;
    else if (pos >= tia_pkg::half_line) return 2'd1;
    else return 2'd0;
  endfunction

  task automatic check_pixel(input tia_pkg::lum_t want_l, input tia_pkg::color_t want_c);
    if (l !== want_l) begin
      $display("FAIL l: expected %h, got %h at %0t", want_l, l, $time);
      pixel_errors++;
    end
    if (c !== want_c) begin
      $display("FAIL c: expected %h, got %h at %0t", want_c, c, $time);
      pixel_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic want, input logic got);
    if (got !== want) begin
      $display("FAIL %s: expected %h, got %h at %0t", name, want, got, $time);
      bit_errors++;
    end
  endtask

  initial begin : stimulus
    logic [31:0] r;
    a = '0;
    d = '0;
    we = 1'b0;
    forever begin
      @(posedge clk);
      if (rst) begin
        we <= 1'b0;
      end else begin
        take_bits(6, r);
        if (r[5:0] == 6'd0) begin  // rare wsync
          a  <= tia_pkg::addr_wsync;
          we <= 1'b1;
        end else begin
          take_bits(4, r);
          if (r[3:0] < 4'd3) begin
            take_bits(4, r);
            if (r[3:0] >= 4'd10) a <= addr_for(r[3:0] - 4'd10);
            else a <= addr_for(r[3:0]);
            take_bits(8, r);
            d  <= r[7:0];
            we <= 1'b1;
          end else begin
            we <= 1'b0;
          end
        end
      end
    end
  end

  // model sees the inputs held before this edge
  always @(posedge clk) begin : model
    tia_pkg::write_word_u w;
    logic [1:0]           k;
    w = d;
    if (rst) begin
      m_hpos = '0;
      m_vsync = 1'b0;
      m_vblank = 1'b0;
      m_reflect = 1'b0;
      m_score = 1'b0;
      m_pf0 = '0;
      m_pf1 = '0;
      m_pf2 = '0;
      m_col[0] = '0;
      m_col[1] = '0;
      m_col[2] = '0;
      m_col[3] = '0;
      m_rdy = 1'b1;
      exp_l = '0;
      exp_c = '0;
      exp_blk = 1'b0;
      exp_syn = 1'b0;
    end else begin
      exp_syn = m_vsync || (m_hpos >= tia_pkg::hsync_start && m_hpos < tia_pkg::hsync_end);
      if (m_vblank || m_hpos < tia_pkg::hblank_end) begin
        exp_l = '0;
        exp_c = '0;
        exp_blk = 1'b0;
      end else begin
        k = pixel_source(m_hpos);
        exp_l = m_col[k].color.lum;
        exp_c = m_col[k].color.hue;
        exp_blk = 1'b1;
      end
      if (we && a == tia_pkg::addr_wsync) m_rdy = 1'b0;
      else if (m_hpos == tia_pkg::line_clocks - 8'd1) m_rdy = 1'b1;
      if (we) begin
        case (a)
          tia_pkg::addr_vsync:  m_vsync = w.ctrl.flag;
          tia_pkg::addr_vblank: m_vblank = w.ctrl.flag;
          tia_pkg::addr_colup0: m_col[0] = w;
          tia_pkg::addr_colup1: m_col[1] = w;
          tia_pkg::addr_colupf: m_col[2] = w;
          tia_pkg::addr_colubk: m_col[3] = w;
          tia_pkg::addr_ctrlpf: begin
            m_reflect = w.ctrl.reflect;
            m_score = w.ctrl.flag;
          end
          tia_pkg::addr_pf0: m_pf0 = w.raw;
          tia_pkg::addr_pf1: m_pf1 = w.raw;
          tia_pkg::addr_pf2: m_pf2 = w.raw;
          default: ;
        endcase
      end
      if (m_hpos == tia_pkg::line_clocks - 8'd1) m_hpos = '0;
      else m_hpos = m_hpos + 8'd1;
    end
    armed = 1'b1;
  end

  always @(negedge clk) begin
    if (armed) begin
      check_pixel(exp_l, exp_c);
      check_bit("blk_bar", exp_blk, blk_bar);
      check_bit("syn", exp_syn, syn);
      check_bit("rdy", m_rdy, rdy);
    end
  end

  initial begin
    @(negedge rst);
    repeat (run_cycles) @(posedge clk);
    @(negedge clk);
    #1;
    $display("pixel errors %0d, control errors %0d", pixel_errors, bit_errors);
    if (pixel_errors == 0 && bit_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    #(timeout_ns);
    $display("timeout: the test did not finish in the expected time");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/tia_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tia_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int half_period = 20;  // 40 ns colour clock
  localparam int reset_cycles = 10;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* logic/tia_video.sv */
`timescale 1ns/1ps
`default_nettype none

module tia_video (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [5:0]            a,
  input  wire [7:0]            d,
  input  wire                  we,
  output tia_pkg::lum_t        l,
  output tia_pkg::color_t      c,
  output logic                 blk_bar,
  output logic                 syn,
  output logic                 rdy
);

  logic            vsync, vblank, wsync_req, reflect, score;
  tia_pkg::lum_t   colup0_l, colup1_l, colupf_l, colubk_l;
  tia_pkg::color_t colup0_c, colup1_c, colupf_c, colubk_c;
  logic [19:0]     pf20;
  tia_pkg::hpos_t  hpos;
  logic            hsync, hblank, right_half, pf_bit;

  tia_write_registers write_registers (
    .clk(clk), .rst(rst), .a(a), .d(d), .we(we),
    .vsync(vsync), .vblank(vblank), .wsync_req(wsync_req),
    .reflect(reflect), .score(score),
    .colup0_l(colup0_l), .colup0_c(colup0_c),
    .colup1_l(colup1_l), .colup1_c(colup1_c),
    .colupf_l(colupf_l), .colupf_c(colupf_c),
    .colubk_l(colubk_l), .colubk_c(colubk_c),
    .pf20(pf20)
  );

  tia_horizontal_timing horizontal_timing (
    .clk(clk), .rst(rst), .wsync_req(wsync_req),
    .hpos(hpos), .hsync(hsync), .hblank(hblank),
    .right_half(right_half), .rdy(rdy)
  );

  tia_playfield playfield (
    .hpos(hpos), .right_half(right_half), .pf20(pf20),
    .reflect(reflect), .pf_bit(pf_bit)
  );

  tia_color_lum color_lum (
    .clk(clk), .rst(rst), .pf_bit(pf_bit), .right_half(right_half),
    .hblank(hblank), .vblank(vblank), .vsync(vsync), .hsync(hsync),
    .score(score),
    .colup0_l(colup0_l), .colup0_c(colup0_c),
    .colup1_l(colup1_l), .colup1_c(colup1_c),
    .colupf_l(colupf_l), .colupf_c(colupf_c),
    .colubk_l(colubk_l), .colubk_c(colubk_c),
    .l(l), .c(c), .blk_bar(blk_bar), .syn(syn)
  );

endmodule

`default_nettype wire

/* logic/tia_color_lum.sv */
`timescale 1ns/1ps
`default_nettype none

module tia_color_lum (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  pf_bit,
  input  wire                  right_half,
  input  wire                  hblank,
  input  wire                  vblank,
  input  wire                  vsync,
  input  wire                  hsync,
  input  wire                  score,
  input  wire tia_pkg::lum_t   colup0_l,
  input  wire tia_pkg::color_t colup0_c,
  input  wire tia_pkg::lum_t   colup1_l,
  input  wire tia_pkg::color_t colup1_c,
  input  wire tia_pkg::lum_t   colupf_l,
  input  wire tia_pkg::color_t colupf_c,
  input  wire tia_pkg::lum_t   colubk_l,
  input  wire tia_pkg::color_t colubk_c,
  output tia_pkg::lum_t        l,
  output tia_pkg::color_t      c,
  output logic                 blk_bar,
  output logic                 syn
);

  tia_pkg::lum_t   pix_l;
  tia_pkg::color_t pix_c;

  always_comb begin
    if (pf_bit && score && right_half) begin
      pix_l = colup1_l;
      pix_c = colup1_c;
    end else if (pf_bit && score) begin
      pix_l = colup0_l;
      pix_c = colup0_c;
    end else if (pf_bit) begin
      pix_l = colupf_l;
      pix_c = colupf_c;
    end else begin
      pix_l = colubk_l;  // background
      pix_c = colubk_c;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      l       <= '0;
      c       <= '0;
      blk_bar <= 1'b0;
      syn     <= 1'b0;
    end else begin
      syn <= hsync | vsync;
      if (hblank || vblank) begin
        l       <= '0;
        c       <= '0;
        blk_bar <= 1'b0;
      end else begin
        l       <= pix_l;
        c       <= pix_c;
        blk_bar <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/tia_playfield.sv */
`timescale 1ns/1ps
`default_nettype none

module tia_playfield (
  input  wire tia_pkg::hpos_t hpos,
  input  wire                 right_half,
  input  wire [19:0]          pf20,
  input  wire                 reflect,
  output logic                pf_bit
);

  tia_pkg::hpos_t col;
  logic [5:0]     slot;
  logic [5:0]     rel;
  logic           in_blank;

  assign in_blank = (hpos < tia_pkg::hblank_end);
  assign col      = hpos - tia_pkg::hblank_end;  // picture column 0..159
  assign slot     = col[7:2];                    // four clocks per playfield bit

  always_comb begin
    if (!right_half) begin
      rel = slot;
    end else if (reflect) begin
      rel = 6'd39 - slot;  // mirror image
    end else begin
      rel = slot - 6'd20;
    end
  end

  assign pf_bit = !in_blank && pf20[rel[4:0]];

endmodule

`default_nettype wire

/* logic/tia_horizontal_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module tia_horizontal_timing (
  input  wire            clk,
  input  wire            rst,
  input  wire            wsync_req,
  output tia_pkg::hpos_t hpos,
  output logic           hsync,
  output logic           hblank,
  output logic           right_half,
  output logic           rdy
);

  logic line_end;

  assign line_end = (hpos == tia_pkg::line_clocks - 8'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      hpos <= '0;
    end else if (line_end) begin
      hpos <= '0;
    end else begin
      hpos <= hpos + 8'd1;
    end
  end

  // cpu halt until the next line starts
  always_ff @(posedge clk) begin
    if (rst) begin
      rdy <= 1'b1;
    end else if (wsync_req) begin
      rdy <= 1'b0;  // a late wsync waits a full line
    end else if (line_end) begin
      rdy <= 1'b1;
    end
  end

  // windows decoded at fixed counter states
  assign hblank     = (hpos < tia_pkg::hblank_end);
  assign hsync      = (hpos >= tia_pkg::hsync_start) && (hpos < tia_pkg::hsync_end);
  assign right_half = (hpos >= tia_pkg::half_line);

endmodule

`default_nettype wire

/* logic/tia_write_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module tia_write_registers (
  input  wire                  clk,
  input  wire                  rst,
  input  wire [5:0]            a,
  input  wire tia_pkg::write_word_u d,
  input  wire                  we,
  output logic                 vsync,
  output logic                 vblank,
  output logic                 wsync_req,
  output logic                 reflect,
  output logic                 score,
  output tia_pkg::lum_t        colup0_l,
  output tia_pkg::color_t      colup0_c,
  output tia_pkg::lum_t        colup1_l,
  output tia_pkg::color_t      colup1_c,
  output tia_pkg::lum_t        colupf_l,
  output tia_pkg::color_t      colupf_c,
  output tia_pkg::lum_t        colubk_l,
  output tia_pkg::color_t      colubk_c,
  output logic [19:0]          pf20
);

  logic [7:0] d_rev;

  // PF1 is shown msb first
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      d_rev[i] = d.raw[7 - i];
    end
  end

  assign wsync_req = we && (a == tia_pkg::addr_wsync);  // strobe only, nothing kept

  always_ff @(posedge clk) begin
    if (rst) begin
      vsync    <= 1'b0;
      vblank   <= 1'b0;
      reflect  <= 1'b0;
      score    <= 1'b0;
      colup0_l <= '0;
      colup0_c <= '0;
      colup1_l <= '0;
      colup1_c <= '0;
      colupf_l <= '0;
      colupf_c <= '0;
      colubk_l <= '0;
      colubk_c <= '0;
      pf20     <= '0;
    end else if (we) begin
      case (a)
        tia_pkg::addr_vsync:  vsync  <= d.ctrl.flag;
        tia_pkg::addr_vblank: vblank <= d.ctrl.flag;
        tia_pkg::addr_colup0: begin
          colup0_l <= d.color.lum;
          colup0_c <= d.color.hue;
        end
        tia_pkg::addr_colup1: begin
          colup1_l <= d.color.lum;
          colup1_c <= d.color.hue;
        end
        tia_pkg::addr_colupf: begin
          colupf_l <= d.color.lum;
          colupf_c <= d.color.hue;
        end
        tia_pkg::addr_colubk: begin
          colubk_l <= d.color.lum;
          colubk_c <= d.color.hue;
        end
        tia_pkg::addr_ctrlpf: begin
          reflect <= d.ctrl.reflect;
          score   <= d.ctrl.flag;
        end
        tia_pkg::addr_pf0: pf20[3:0]   <= d.raw[7:4];  // low nibble unused
        tia_pkg::addr_pf1: pf20[11:4]  <= d_rev;
        tia_pkg::addr_pf2: pf20[19:12] <= d.raw;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/tia_pkg.sv */
`default_nettype none

package tia_pkg;

  typedef logic [7:0] hpos_t;
  typedef logic [2:0] lum_t;
  typedef logic [3:0] color_t;

  // write addresses
  localparam logic [5:0] addr_vsync  = 6'h00;
  localparam logic [5:0] addr_vblank = 6'h01;
  localparam logic [5:0] addr_wsync  = 6'h02;
  localparam logic [5:0] addr_colup0 = 6'h06;
  localparam logic [5:0] addr_colup1 = 6'h07;
  localparam logic [5:0] addr_colupf = 6'h08;
  localparam logic [5:0] addr_colubk = 6'h09;
  localparam logic [5:0] addr_ctrlpf = 6'h0a;
  localparam logic [5:0] addr_pf0    = 6'h0d;
  localparam logic [5:0] addr_pf1    = 6'h0e;
  localparam logic [5:0] addr_pf2    = 6'h0f;

  // horizontal decode points, in colour clocks
  localparam hpos_t line_clocks = 8'd228;
  localparam hpos_t hsync_start = 8'd20;
  localparam hpos_t hsync_end   = 8'd36;
  localparam hpos_t hblank_end  = 8'd68;
  localparam hpos_t half_line   = 8'd148;  // first clock of right half

  typedef struct packed {
    color_t hue;
    lum_t   lum;
    logic   unused;
  } color_view_t;

  // bit 1 is score for CTRLPF, the level for VSYNC/VBLANK
  typedef struct packed {
    logic [5:0] unused;
    logic       flag;
    logic       reflect;
  } ctrl_view_t;

  typedef union packed {
    color_view_t color;
    ctrl_view_t  ctrl;
    logic [7:0]  raw;  // playfield graphics bytes
  } write_word_u;

endpackage

`default_nettype wire
